// File: run.sh
#!/bin/sh
# build the core testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timescale 1ns/100ps --top-module cpuTb -f sources.f -o cpuTbSim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/cpuTbSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "RESULT: FAIL" sim.log; then
	exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
	echo "no verdict found in sim.log"
	exit 1
fi
exit 0

// File: sim/tbIss.svh
// instruction-set model and program generator
`ifndef TB_ISS_SVH
`define TB_ISS_SVH

// slot kinds for the generator
localparam int K_R = 0;
localparam int K_I = 1;
localparam int K_LUI = 2;
localparam int K_LW = 3;
localparam int K_SW = 4;
localparam int K_BR = 5;
localparam int K_JAL = 6;
localparam int K_GLUI = 7;
localparam int K_GADDI = 8;
localparam int K_GJALR = 9;
localparam int K_EBREAK = 10;

localparam word_t EBREAK_WORD = 32'h0010_0073;

int kind [PROG_LEN];
// slots inside a jalr group, never a branch target
bit noLand [PROG_LEN];

// RV32I field packing
function automatic word_t encR(logic [6:0] f7, regIdx_t rs2, regIdx_t rs1, logic [2:0] f3,
	regIdx_t rd);
	return {f7, rs2, rs1, f3, rd, OPC_OP};
endfunction

function automatic word_t encI(word_t imm, regIdx_t rs1, logic [2:0] f3, regIdx_t rd,
	logic [6:0] op);
	return {imm[11:0], rs1, f3, rd, op};
endfunction

function automatic word_t encS(word_t imm, regIdx_t rs2, regIdx_t rs1);
	return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
endfunction

function automatic word_t encB(word_t off, regIdx_t rs2, regIdx_t rs1, logic [2:0] f3);
	return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
endfunction

function automatic word_t encU(logic [19:0] imm, regIdx_t rd);
	return {imm, rd, OPC_LUI};
endfunction

function automatic word_t encJ(word_t off, regIdx_t rd);
	return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
endfunction

// 0 and 1 are add/sub, the rest and/or/xor/slt
function automatic logic [2:0] funct3For(int sel);
	case (sel)
		2: return 3'b111;
		3: return 3'b110;
		4: return 3'b100;
		5: return 3'b010;
		default: return 3'b000;
	endcase
endfunction

function automatic int kindOf(int pick);
	if (pick <= 4) return K_R;
	if (pick <= 7) return K_I;
	if (pick == 8) return K_LUI;
	if (pick <= 10) return K_LW;
	if (pick <= 12) return K_SW;
	if (pick == 13) return K_BR;
	return K_JAL;
endfunction

function automatic regIdx_t destReg();
	return regIdx_t'(randBits(3) % 7 + 1);
endfunction

// x0 included on purpose
function automatic regIdx_t srcReg();
	return regIdx_t'(randBits(3));
endfunction

// mostly array words, now and then the LED register
function automatic word_t memAddr();
	if (randBits(3) == 0) return LED_ADDR;
	return word_t'(randBits(DIDX) * 4);
endfunction

// forward target, pushed past group interiors
function automatic int landTarget(int from, int skip);
	int t;
	t = from + skip;
	if (t > PROG_LEN - 1) t = PROG_LEN - 1;
	while (noLand[t]) t++;
	return t;
endfunction

task automatic genProgram();
	int i;
	int pick;
	int t;
	regIdx_t k;
	for (int n = 0; n < ROM_WORDS; n++) begin
		rom[n] = NOP_WORD;
	end
	for (int n = 0; n < PROG_LEN; n++) begin
		noLand[n] = 1'b0;
	end
	// first pass lays out kinds, jalr groups take three slots
	i = 0;
	while (i < PROG_LEN - 1) begin
		pick = int'(randBits(4));
		if (pick == 15 && i + 3 < PROG_LEN - 1) begin
			kind[i] = K_GLUI;
			kind[i + 1] = K_GADDI;
			kind[i + 2] = K_GJALR;
			noLand[i + 1] = 1'b1;
			noLand[i + 2] = 1'b1;
			i += 3;
		end else begin
			kind[i] = kindOf(pick);
			i++;
		end
	end
	kind[PROG_LEN - 1] = K_EBREAK;
	// second pass fills in words
	for (i = 0; i < PROG_LEN; i++) begin
		case (kind[i])
			K_R: begin
				pick = int'(randBits(3) % 6);
				rom[i] = encR((pick == 1) ? 7'b0100000 : 7'b0, srcReg(), srcReg(),
					funct3For(pick), destReg());
			end
			K_I: begin
				pick = int'(randBits(3) % 5) + 1;
				rom[i] = encI(word_t'(randBits(12)), srcReg(), funct3For(pick), destReg(),
					OPC_OPIMM);
			end
			K_LUI: rom[i] = encU(20'(randBits(20)), destReg());
			K_LW: rom[i] = encI(memAddr(), 5'd0, 3'b010, destReg(), OPC_LOAD);
			K_SW: rom[i] = encS(memAddr(), srcReg(), 5'd0);
			K_BR: begin
				t = landTarget(i, 2 + int'(randBits(2)));
				pick = int'(randBits(2) % 3);
				rom[i] = encB(word_t'((t - i) * 4), srcReg(), srcReg(),
					(pick == 0) ? 3'b000 : (pick == 1) ? 3'b001 : 3'b100);
			end
			K_JAL: begin
				t = landTarget(i, 2 + int'(randBits(2)));
				rom[i] = encJ(word_t'((t - i) * 4), destReg());
			end
			K_GLUI: begin
				// lui/addi build the address, jalr uses it right away
				k = destReg();
				t = landTarget(i + 2, 2 + int'(randBits(2)));
				rom[i] = encU(20'd0, k);
				rom[i + 1] = encI(word_t'(t * 4), k, 3'b000, k, OPC_OPIMM);
				rom[i + 2] = encI(32'd0, k, 3'b000, destReg(), OPC_JALR);
			end
			K_EBREAK: rom[i] = EBREAK_WORD;
			default: begin
			end
		endcase
	end
endtask

// RV32I add/sub/logic/slt, per funct3
function automatic word_t aluRef(logic [2:0] f3, logic sub, word_t a, word_t b);
	case (f3)
		3'b000: return sub ? a - b : a + b;
		3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		3'b100: return a ^ b;
		3'b110: return a | b;
		3'b111: return a & b;
		default: return 32'd0;
	endcase
endfunction

// in-order execution, one record per retired instruction
task automatic runIss();
	word_t xr [32];
	word_t dmemRef [DMEM_WORDS];
	word_t pc, w, a, b, res, nextPc, addr;
	word_t immI, immS, immB, immJ;
	retire_t rec;
	logic wr, done;
	int steps;
	for (int n = 0; n < 32; n++) begin
		xr[n] = '0;
	end
	for (int n = 0; n < DMEM_WORDS; n++) begin
		dmemRef[n] = '0;
	end
	ledExp = '0;
	pc = PC_RESET;
	done = 1'b0;
	steps = 0;
	while (!done && steps < 2 * PROG_LEN) begin
		w = rom[pc[9:2]];
		a = xr[w[19:15]];
		b = xr[w[24:20]];
		immI = {{20{w[31]}}, w[31:20]};
		immS = {{20{w[31]}}, w[31:25], w[11:7]};
		immB = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
		immJ = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
		nextPc = pc + 32'd4;
		wr = 1'b0;
		res = '0;
		case (w[6:0])
			OPC_OP: begin
				wr = 1'b1;
				res = aluRef(w[14:12], w[30], a, b);
			end
			OPC_OPIMM: begin
				wr = 1'b1;
				res = aluRef(w[14:12], 1'b0, a, immI);
			end
			OPC_LUI: begin
				wr = 1'b1;
				res = {w[31:12], 12'b0};
			end
			OPC_LOAD: begin
				wr = 1'b1;
				addr = a + immI;
				res = (addr == LED_ADDR) ? {24'b0, ledExp} : dmemRef[addr[DIDX+1:2]];
			end
			OPC_STORE: begin
				addr = a + immS;
				if (addr == LED_ADDR) ledExp = b[7:0];
				else dmemRef[addr[DIDX+1:2]] = b;
			end
			OPC_BRANCH: begin
				if ((w[14:12] == 3'b000 && a == b) || (w[14:12] == 3'b001 && a != b) ||
					(w[14:12] == 3'b100 && $signed(a) < $signed(b))) begin
					nextPc = pc + immB;
				end
			end
			OPC_JAL: begin
				wr = 1'b1;
				res = pc + 32'd4;
				nextPc = pc + immJ;
			end
			OPC_JALR: begin
				wr = 1'b1;
				res = pc + 32'd4;
				nextPc = (a + immI) & ~32'd1;
			end
			default: done = (w == EBREAK_WORD);
		endcase
		if (w[11:7] == 5'd0) wr = 1'b0;
		rec.pc = pc;
		rec.rd = w[11:7];
		rec.wen = wr;
		rec.data = res;
		expQ.push_back(rec);
		if (wr) xr[w[11:7]] = res;
		pc = nextPc;
		steps++;
	end
	if (!done) begin
		$display("reference model never reached ebreak");
		abortRun();
	end
endtask

`endif

// File: sim/cpuTb.sv
// pipelined core testbench
module cpuTb import cpuPkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD = 40;
	localparam int PROG_LEN = 200;
	localparam int ROM_WORDS = 256;
	localparam int DMEM_WORDS = 64;
	localparam int DIDX = $clog2(DMEM_WORDS);
	localparam int RESET_CYCLES = 10;
	// 20 cycles per instruction plus reset
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + 20 * PROG_LEN;
	localparam word_t NOP_WORD = 32'h0000_0013;
	localparam logic [31:0] LFSR_SEED = 32'hfafb;

	typedef struct packed {
		word_t pc;
		regIdx_t rd;
		logic wen;
		word_t data;
	} retire_t;

	logic clk = 1'b0;
	logic rstN;
	word_t imemAddr;
	word_t imemData;
	logic retireValid;
	word_t retirePc;
	regIdx_t retireRd;
	logic retireWen;
	word_t retireData;
	logic [7:0] led;
	logic halted;

	word_t rom [ROM_WORDS];
	retire_t expQ [$];
	retire_t want;
	logic [7:0] ledExp;
	logic [31:0] lfsr;
	int retired = 0;

	// print the verdict and stop
	task automatic abortRun();
		$display("RESULT: FAIL");
		$fatal(1);
	endtask

	// taps 32,22,2,1
	function automatic logic lfsrStep();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic int unsigned randBits(int n);
		int unsigned v;
		v = 0;
		for (int k = 0; k < n; k++) begin
			v = (v << 1) | {31'b0, lfsrStep()};
		end
		return v;
	endfunction

	`include "tbIss.svh"

	task automatic checkWord(string name, word_t expVal, word_t actVal);
		if (expVal !== actVal) begin
			$display("[FAIL] t=%0t %s expected %h got %h", $time, name, expVal, actVal);
			abortRun();
		end
	endtask

	task automatic checkIdx(string name, regIdx_t expVal, regIdx_t actVal);
		if (expVal !== actVal) begin
			$display("[FAIL] t=%0t %s expected %0d got %0d", $time, name, expVal, actVal);
			abortRun();
		end
	endtask

	task automatic checkBit(string name, logic expVal, logic actVal);
		if (expVal !== actVal) begin
			$display("[FAIL] t=%0t %s expected %b got %b", $time, name, expVal, actVal);
			abortRun();
		end
	endtask

	task automatic checkLed(string name, logic [7:0] expVal, logic [7:0] actVal);
		if (expVal !== actVal) begin
			$display("[FAIL] t=%0t %s expected %h got %h", $time, name, expVal, actVal);
			abortRun();
		end
	endtask

	cpuTop #(.DMEM_WORDS(DMEM_WORDS)) dut0 (
		.clk(clk),
		.rstN(rstN),
		.imemAddr(imemAddr),
		.imemData(imemData),
		.retireValid(retireValid),
		.retirePc(retirePc),
		.retireRd(retireRd),
		.retireWen(retireWen),
		.retireData(retireData),
		.led(led),
		.halted(halted)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// instruction ROM answers within the fetch cycle
	assign imemData = (imemAddr < 32'(ROM_WORDS * 4)) ? rom[imemAddr[9:2]] : NOP_WORD;

	// retire port checked mid-cycle, in program order
	always @(negedge clk) begin
		if (rstN && retireValid) begin
			if (retired >= expQ.size()) begin
				$display("core retired more instructions than the model at t=%0t", $time);
				abortRun();
			end
			want = expQ[retired];
			checkWord("retirePc", want.pc, retirePc);
			checkBit("retireWen", want.wen, retireWen);
			// rd and data only mean something for writes
			if (want.wen) begin
				checkIdx("retireRd", want.rd, retireRd);
				checkWord("retireData", want.data, retireData);
			end
			retired++;
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired before the core halted");
		abortRun();
	end

	initial begin
		lfsr = LFSR_SEED;
		rstN = 1'b0;
		genProgram();
		runIss();
		repeat (RESET_CYCLES) @(posedge clk);
		rstN <= 1'b1;
		while (halted !== 1'b1) begin
			@(posedge clk);
		end
		// halted must stick, nothing else may retire
		repeat (8) begin
			@(negedge clk);
			checkBit("halted", 1'b1, halted);
		end
		checkLed("led", ledExp, led);
		if (retired != expQ.size()) begin
			$display("core retired %0d instructions, model expects %0d", retired, expQ.size());
			abortRun();
		end else begin
			$display("RESULT: PASS");
			$finish;
		end
	end

endmodule

// File: sources.f
+incdir+sim
src/cpuPkg.sv
src/alu.sv
src/decoder.sv
src/regFile.sv
src/forwardUnit.sv
src/dataMem.sv
src/cpuTop.sv
sim/cpuTb.sv

// File: src/alu.sv
// execute-stage ALU
module alu import cpuPkg::*; (
	input word_t a,
	input word_t b,
	input aluOp_t op,
	output word_t result,
	output logic lessThan,
	output logic equal
);
	// compare flags feed branch resolution too
	assign lessThan = $signed(a) < $signed(b);
	assign equal = (a == b);

	always_comb begin
		case (op)
			ALU_ADD: result = a + b;
			ALU_SUB: result = a - b;
			ALU_AND: result = a & b;
			ALU_OR: result = a | b;
			ALU_XOR: result = a ^ b;
			ALU_SLT: result = {31'b0, lessThan};
			// lui
			ALU_PASSB: result = b;
			default: result = '0;
		endcase
	end

endmodule

// File: src/cpuPkg.sv
// core-wide types and constants
package cpuPkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] regIdx_t;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_PASSB
	} aluOp_t;

	typedef enum logic [2:0] {
		BR_NONE,
		BR_EQ,
		BR_NE,
		BR_LT,
		BR_JAL,
		BR_JALR
	} brOp_t;

	// one instruction word, viewed through each base format
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			regIdx_t rs2;
			regIdx_t rs1;
			logic [2:0] funct3;
			regIdx_t rd;
			logic [6:0] opcode;
		} r;
		struct packed {
			logic [11:0] imm;
			regIdx_t rs1;
			logic [2:0] funct3;
			regIdx_t rd;
			logic [6:0] opcode;
		} i;
		struct packed {
			logic [6:0] immHi;
			regIdx_t rs2;
			regIdx_t rs1;
			logic [2:0] funct3;
			logic [4:0] immLo;
			logic [6:0] opcode;
		} s;
		struct packed {
			logic imm12;
			logic [5:0] imm10to5;
			regIdx_t rs2;
			regIdx_t rs1;
			logic [2:0] funct3;
			logic [3:0] imm4to1;
			logic imm11;
			logic [6:0] opcode;
		} b;
		struct packed {
			logic [19:0] imm;
			regIdx_t rd;
			logic [6:0] opcode;
		} u;
		struct packed {
			logic imm20;
			logic [9:0] imm10to1;
			logic imm11;
			logic [7:0] imm19to12;
			regIdx_t rd;
			logic [6:0] opcode;
		} j;
	} instr_t;

	// major opcodes
	localparam logic [6:0] OPC_OP = 7'b0110011;
	localparam logic [6:0] OPC_OPIMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI = 7'b0110111;
	localparam logic [6:0] OPC_LOAD = 7'b0000011;
	localparam logic [6:0] OPC_STORE = 7'b0100011;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_JAL = 7'b1101111;
	localparam logic [6:0] OPC_JALR = 7'b1100111;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

	// operand source in EX
	localparam logic [1:0] FWD_RF = 2'd0;
	localparam logic [1:0] FWD_MEM = 2'd1;
	localparam logic [1:0] FWD_WB = 2'd2;

	localparam word_t PC_RESET = 32'h0000_0000;
	localparam word_t LED_ADDR = 32'h0000_0100;

endpackage

// decoded control bundle
interface decodeIf import cpuPkg::*; ();
	regIdx_t rs1;
	regIdx_t rs2;
	regIdx_t rd;
	word_t imm;
	aluOp_t aluOp;
	brOp_t brOp;
	logic useImm;
	logic regWen;
	logic memRen;
	logic memWen;
	logic isEbreak;

	modport producer (
		output rs1, rs2, rd, imm, aluOp, brOp,
		output useImm, regWen, memRen, memWen, isEbreak
	);
	modport consumer (
		input rs1, rs2, rd, imm, aluOp, brOp,
		input useImm, regWen, memRen, memWen, isEbreak
	);
endinterface

// File: src/cpuTop.sv
// five-stage RV32I subset core
module cpuTop import cpuPkg::*; #(
	parameter int DMEM_WORDS = 64
) (
	input logic clk,
	input logic rstN,
	output word_t imemAddr,
	input word_t imemData,
	output logic retireValid,
	output word_t retirePc,
	output regIdx_t retireRd,
	output logic retireWen,
	output word_t retireData,
	output logic [7:0] led,
	output logic halted
);
	// fetch state
	word_t pc;
	logic ebreakSeen;
	logic stopFetch;
	// IF/ID
	logic ifIdValid;
	word_t ifIdPc;
	instr_t ifIdInstr;
	// decode side
	word_t rfData1, rfData2;
	logic [1:0] sel1, sel2;
	logic stall, hold;
	// ID/EX
	logic idExValid;
	word_t idExPc, idExImm, idExRs1Data, idExRs2Data;
	regIdx_t idExRd;
	aluOp_t idExAluOp;
	brOp_t idExBrOp;
	logic idExUseImm, idExRegWen, idExMemRen, idExMemWen, idExEbreak;
	logic [1:0] idExSel1, idExSel2;
	// execute side
	word_t opA, opB, aluResult, target, exResult;
	logic lessThan, equal, brTaken, taken;
	// EX/MEM
	logic exMemValid;
	word_t exMemPc, exMemResult, exMemStoreData;
	regIdx_t exMemRd;
	logic exMemRegWen, exMemMemRen, exMemMemWen, exMemEbreak;
	word_t dmemRdata;
	// MEM/WB
	logic memWbValid;
	word_t memWbPc, memWbResult, memWbLoadData, wbData;
	regIdx_t memWbRd;
	logic memWbRegWen, memWbLoad, memWbEbreak;

	function automatic word_t pickSrc(logic [1:0] sel, word_t rfVal, word_t memVal,
		word_t wbVal);
		case (sel)
			FWD_MEM: return memVal;
			FWD_WB: return wbVal;
			default: return rfVal;
		endcase
	endfunction

	decodeIf dec0 ();

	decoder decoder0 (.instr(ifIdInstr), .dec(dec0.producer));

	regFile rf0 (
		.clk(clk), .rstN(rstN),
		.raddr1(dec0.rs1), .raddr2(dec0.rs2),
		.waddr(memWbRd), .wdata(wbData), .wen(memWbValid && memWbRegWen),
		.rdata1(rfData1), .rdata2(rfData2)
	);

	// write enables only count for live stages
	forwardUnit fwd0 (
		.rs1(dec0.rs1), .rs2(dec0.rs2),
		.rdEx(idExRd), .rdMem(exMemRd), .rdWb(memWbRd),
		.wenEx(idExValid && idExRegWen), .wenMem(exMemValid && exMemRegWen),
		.wenWb(memWbValid && memWbRegWen), .loadEx(idExValid && idExMemRen),
		.sel1(sel1), .sel2(sel2), .stall(stall)
	);

	alu alu0 (
		.a(opA), .b(idExUseImm ? idExImm : opB), .op(idExAluOp),
		.result(aluResult), .lessThan(lessThan), .equal(equal)
	);

	dataMem #(.DMEM_WORDS(DMEM_WORDS)) dmem0 (
		.clk(clk), .rstN(rstN),
		.addr(exMemResult), .wdata(exMemStoreData),
		.wen(exMemValid && exMemMemWen), .ren(exMemValid && exMemMemRen),
		.rdata(dmemRdata), .led(led)
	);

	assign imemAddr = pc;
	// an empty IF/ID slot never stalls
	assign hold = stall && ifIdValid;
	// nothing past an ebreak enters the pipe
	assign stopFetch = ebreakSeen || (ifIdValid && dec0.isEbreak);

	// EX operands
	assign opA = pickSrc(idExSel1, idExRs1Data, exMemResult, wbData);
	assign opB = pickSrc(idExSel2, idExRs2Data, exMemResult, wbData);

	always_comb begin
		case (idExBrOp)
			BR_EQ: brTaken = equal;
			BR_NE: brTaken = !equal;
			BR_LT: brTaken = lessThan;
			BR_JAL, BR_JALR: brTaken = 1'b1;
			default: brTaken = 1'b0;
		endcase
	end

	assign taken = idExValid && brTaken;
	// jalr drops bit 0 of rs1+imm
	assign target = (idExBrOp == BR_JALR) ? {aluResult[31:1], 1'b0} : idExPc + idExImm;
	// jumps link pc+4
	assign exResult = (idExBrOp == BR_JAL || idExBrOp == BR_JALR) ? idExPc + 32'd4 : aluResult;

	assign wbData = memWbLoad ? memWbLoadData : memWbResult;

	// valid bits and fetch control
	always_ff @(posedge clk) begin
		if (!rstN) begin
			pc <= PC_RESET;
			ebreakSeen <= 1'b0;
			ifIdValid <= 1'b0;
			idExValid <= 1'b0;
			exMemValid <= 1'b0;
			memWbValid <= 1'b0;
			halted <= 1'b0;
		end else begin
			if (ifIdValid && dec0.isEbreak && !taken) begin
				ebreakSeen <= 1'b1;
			end
			// redirect beats everything, stall freezes PC and IF/ID
			if (taken) begin
				pc <= target;
				ifIdValid <= 1'b0;
			end else if (!hold) begin
				ifIdValid <= !stopFetch;
				if (!stopFetch) begin
					pc <= pc + 32'd4;
				end
			end
			idExValid <= ifIdValid && !taken && !hold;
			exMemValid <= idExValid;
			memWbValid <= exMemValid;
			if (memWbValid && memWbEbreak) begin
				halted <= 1'b1;
			end
		end
	end

	// pipeline payload
	always_ff @(posedge clk) begin
		if (!hold) begin
			ifIdPc <= pc;
			ifIdInstr <= imemData;
		end
		idExPc <= ifIdPc;
		idExImm <= dec0.imm;
		idExRs1Data <= rfData1;
		idExRs2Data <= rfData2;
		idExRd <= dec0.rd;
		idExAluOp <= dec0.aluOp;
		idExBrOp <= dec0.brOp;
		idExUseImm <= dec0.useImm;
		idExRegWen <= dec0.regWen;
		idExMemRen <= dec0.memRen;
		idExMemWen <= dec0.memWen;
		idExEbreak <= dec0.isEbreak;
		idExSel1 <= sel1;
		idExSel2 <= sel2;
		exMemPc <= idExPc;
		exMemResult <= exResult;
		// store data honours forwarding as well
		exMemStoreData <= opB;
		exMemRd <= idExRd;
		exMemRegWen <= idExRegWen;
		exMemMemRen <= idExMemRen;
		exMemMemWen <= idExMemWen;
		exMemEbreak <= idExEbreak;
		memWbPc <= exMemPc;
		memWbResult <= exMemResult;
		memWbLoadData <= dmemRdata;
		memWbRd <= exMemRd;
		memWbRegWen <= exMemRegWen;
		memWbLoad <= exMemMemRen;
		memWbEbreak <= exMemEbreak;
	end

	// retire straight out of MEM/WB
	assign retireValid = memWbValid;
	assign retirePc = memWbPc;
	assign retireRd = memWbRd;
	assign retireWen = memWbRegWen;
	assign retireData = wbData;

	// the ebreak is the last thing that ever retires
	assert property (@(posedge clk) disable iff (!rstN) halted |-> !retireValid);

endmodule

// File: src/dataMem.sv
// data memory with mapped LED register
module dataMem import cpuPkg::*; #(
	parameter int DMEM_WORDS = 64
) (
	input logic clk,
	input logic rstN,
	input word_t addr,
	input word_t wdata,
	input logic wen,
	input logic ren,
	output word_t rdata,
	output logic [7:0] led
);
	localparam int IDX_W = $clog2(DMEM_WORDS);

	word_t mem [DMEM_WORDS];
	logic [IDX_W-1:0] idx;
	logic isLed;

	// word index wraps at the array depth
	assign idx = addr[IDX_W+1:2];
	assign isLed = (addr == LED_ADDR);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int k = 0; k < DMEM_WORDS; k++) begin
				mem[k] <= '0;
			end
			led <= '0;
		end else if (wen) begin
			// LED address shadows its array slot
			if (isLed) begin
				led <= wdata[7:0];
			end else begin
				mem[idx] <= wdata;
			end
		end
	end

	// combinational read during MEM
	assign rdata = !ren ? '0 : (isLed ? {24'b0, led} : mem[idx]);

	assert property (@(posedge clk) disable iff (!rstN) (wen || ren) |-> addr[1:0] == 2'b00);

endmodule

// File: src/decoder.sv
// instruction decoder
module decoder import cpuPkg::*; (
	input instr_t instr,
	decodeIf.producer dec
);
	// funct3 map shared by OP and OPIMM
	function automatic aluOp_t aluFromFunct3(logic [2:0] funct3);
		case (funct3)
			3'b010: return ALU_SLT;
			3'b100: return ALU_XOR;
			3'b110: return ALU_OR;
			3'b111: return ALU_AND;
			default: return ALU_ADD;
		endcase
	endfunction

	always_comb begin
		// defaults form a bubble
		dec.rs1 = '0;
		dec.rs2 = '0;
		dec.rd = '0;
		dec.imm = '0;
		dec.aluOp = ALU_ADD;
		dec.brOp = BR_NONE;
		dec.useImm = 1'b0;
		dec.memRen = 1'b0;
		dec.memWen = 1'b0;
		dec.isEbreak = 1'b0;
		case (instr.r.opcode)
			OPC_OP: begin
				dec.rs1 = instr.r.rs1;
				dec.rs2 = instr.r.rs2;
				dec.rd = instr.r.rd;
				// funct7 bit 5 turns add into sub
				if (instr.r.funct3 == 3'b000 && instr.r.funct7[5]) begin
					dec.aluOp = ALU_SUB;
				end else begin
					dec.aluOp = aluFromFunct3(instr.r.funct3);
				end
			end
			OPC_OPIMM, OPC_LOAD, OPC_JALR: begin
				dec.rs1 = instr.i.rs1;
				dec.rd = instr.i.rd;
				dec.imm = {{20{instr.i.imm[11]}}, instr.i.imm};
				dec.useImm = 1'b1;
				if (instr.i.opcode == OPC_OPIMM) begin
					dec.aluOp = aluFromFunct3(instr.i.funct3);
				end
				dec.memRen = (instr.i.opcode == OPC_LOAD);
				// jalr target comes out of the adder
				if (instr.i.opcode == OPC_JALR) begin
					dec.brOp = BR_JALR;
				end
			end
			OPC_LUI: begin
				dec.rd = instr.u.rd;
				dec.imm = {instr.u.imm, 12'b0};
				dec.useImm = 1'b1;
				dec.aluOp = ALU_PASSB;
			end
			OPC_STORE: begin
				dec.rs1 = instr.s.rs1;
				dec.rs2 = instr.s.rs2;
				dec.imm = {{20{instr.s.immHi[6]}}, instr.s.immHi, instr.s.immLo};
				dec.useImm = 1'b1;
				dec.memWen = 1'b1;
			end
			OPC_BRANCH: begin
				dec.rs1 = instr.b.rs1;
				dec.rs2 = instr.b.rs2;
				dec.imm = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
					instr.b.imm10to5, instr.b.imm4to1, 1'b0};
				case (instr.b.funct3)
					3'b000: dec.brOp = BR_EQ;
					3'b001: dec.brOp = BR_NE;
					3'b100: dec.brOp = BR_LT;
					default: dec.brOp = BR_NONE;
				endcase
			end
			OPC_JAL: begin
				dec.rd = instr.j.rd;
				dec.imm = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19to12,
					instr.j.imm11, instr.j.imm10to1, 1'b0};
				dec.brOp = BR_JAL;
			end
			OPC_SYSTEM: begin
				// only ebreak, everything else is a bubble
				dec.isEbreak = (instr.i.funct3 == 3'b000) && (instr.i.imm == 12'h001);
			end
			default: begin
			end
		endcase
		// x0 as destination is never a write
		dec.regWen = (dec.rd != '0);
	end

endmodule

// File: src/forwardUnit.sv
// operand forwarding and load-use detection
module forwardUnit import cpuPkg::*; (
	input regIdx_t rs1,
	input regIdx_t rs2,
	input regIdx_t rdEx,
	input regIdx_t rdMem,
	input regIdx_t rdWb,
	input logic wenEx,
	input logic wenMem,
	input logic wenWb,
	input logic loadEx,
	output logic [1:0] sel1,
	output logic [1:0] sel2,
	output logic stall
);
	// chosen in decode, used one cycle later in EX
	// EX producer will sit in MEM then, MEM producer in WB
	function automatic logic [1:0] pickSel(regIdx_t rs);
		if (rs == '0) return FWD_RF;
		if (wenEx && rdEx == rs) return FWD_MEM;
		if (wenMem && rdMem == rs) return FWD_WB;
		// WB producer lands via the write-through read
		if (wenWb && rdWb == rs) return FWD_RF;
		return FWD_RF;
	endfunction

	assign sel1 = pickSel(rs1);
	assign sel2 = pickSel(rs2);

	// load data only exists in MEM, so one bubble is needed
	assign stall = loadEx && wenEx && (rdEx == rs1 || rdEx == rs2);

	// a write enable never comes with x0 as destination
	always_comb begin
		assert (!(stall && rdEx == '0));
	end

endmodule

// File: src/regFile.sv
// integer register file
module regFile import cpuPkg::*; (
	input logic clk,
	input logic rstN,
	input regIdx_t raddr1,
	input regIdx_t raddr2,
	input regIdx_t waddr,
	input word_t wdata,
	input logic wen,
	output word_t rdata1,
	output word_t rdata2
);
	word_t regs [32];

	// same-cycle write shows up on the read side
	function automatic word_t readPort(regIdx_t idx);
		if (idx == '0) return '0;
		if (wen && idx == waddr) return wdata;
		return regs[idx];
	endfunction

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int k = 0; k < 32; k++) begin
				regs[k] <= '0;
			end
		end else if (wen && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	always_comb begin
		rdata1 = readPort(raddr1);
		rdata2 = readPort(raddr2);
	end

endmodule
